// ==== dv/qcom_cmd_properties.sv ====
////////////////////
// Command path checks
// Request exclusivity, request hold and FIFO
// over and underflow, bound into the top level
////////////////////
`timescale 1ns/1ps

module qcom_cmd_properties #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          i_clk,
    input  logic                          i_rstn,
    input  logic                          i_req_loc,
    input  logic                          i_req_net,
    input  logic                          i_ack,
    input  logic                          i_push,
    input  logic                          i_pop,
    input  logic                          i_empty,
    input  logic [$clog2(FIFO_DEPTH):0]   i_level
);

    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    // One executor at a time
    a_req_excl: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !(i_req_loc && i_req_net))
        else $error("local and network requests high together");

    // Requests stay up until the executor answers
    a_loc_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (i_req_loc && !i_ack) |=> i_req_loc)
        else $error("local request dropped before ack");

    a_net_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (i_req_net && !i_ack) |=> i_req_net)
        else $error("network request dropped before ack");

    // FIFO relies on its neighbors for these
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !(i_push && (i_level == LVL_W'(FIFO_DEPTH))))
        else $error("FIFO pushed while full");

    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !(i_pop && i_empty))
        else $error("FIFO popped while empty");

endmodule

// ==== dv/qcom_cmd_tb.sv ====
////////////////////
// Command path testbench
// Table driven host commands, executor ack model,
// overflow and in-order issue checks
////////////////////
`timescale 1ns/1ps

module qcom_cmd_tb;

    import qcom_cmd_pkg::*;
    import qcom_ctrl_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int NROWS      = 12;
    localparam int TMO        = 200;

    // One table row with stimulus and expected issue
    typedef struct packed {
        logic [HOST_OP_W-1:0] op;
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
        logic [7:0]           dly;
        logic [EXEC_OP_W-1:0] exp_op;
        logic                 exp_loc;
    } row_t;

    logic                   i_clk;
    logic                   i_rstn;
    logic                   i_valid;
    logic [HOST_OP_W-1:0]   i_op;
    logic [ADDR_W-1:0]      i_addr;
    logic [DATA_W-1:0]      i_data;
    logic                   i_ack;
    logic                   o_req_loc;
    logic                   o_req_net;
    logic [EXEC_OP_W-1:0]   o_op;
    logic [DATA_W-1:0]      o_data;
    logic [CNTR_W-1:0]      o_data_cntr;
    logic [CNTR_W-1:0]      o_drop_cntr;

    row_t                   tab [NROWS];
    // Row indices expected to be issued in order
    int                     exp_q [$];
    int                     n_err;
    int                     n_chk;
    int                     n_issued;
    logic                   hold_ack;

    qcom_cmd_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .i_ack       (i_ack),
        .o_req_loc   (o_req_loc),
        .o_req_net   (o_req_net),
        .o_op        (o_op),
        .o_data      (o_data),
        .o_data_cntr (o_data_cntr),
        .o_drop_cntr (o_drop_cntr)
    );

    bind qcom_cmd_top qcom_cmd_properties #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_props (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_req_loc (o_req_loc),
        .i_req_net (o_req_net),
        .i_ack     (i_ack),
        .i_push    (push),
        .i_pop     (pop),
        .i_empty   (empty),
        .i_level   (level)
    );

    // 40 ns clock
    always #20 i_clk = ~i_clk;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_t make_row(input logic [4:0] op, input logic [3:0] addr,
                                      input logic [31:0] data, input logic [7:0] dly,
                                      input logic [7:0] exp_op, input logic exp_loc);
        row_t r;
        r.op      = op;
        r.addr    = addr;
        r.data    = data;
        r.dly     = dly;
        r.exp_op  = exp_op;
        r.exp_loc = exp_loc;
        return r;
    endfunction

    task automatic build_table();
        logic [31:0] seed;
        seed   = 32'h5286164a;
        // Hand written rows with expected op and executor
        tab[0] = make_row(5'h13, 4'h2, 32'hdeadbeef, 8'd8, 8'h32, 1'b1);
        tab[1] = make_row(5'h05, 4'ha, 32'h00000001, 8'd0, 8'h5a, 1'b0);
        tab[2] = make_row(5'h1f, 4'hf, 32'hffffffff, 8'd1, 8'hff, 1'b1);
        tab[3] = make_row(5'h00, 4'h0, 32'h00000000, 8'd2, 8'h00, 1'b0);
        tab[4] = make_row(5'h18, 4'h7, 32'h12345678, 8'd3, 8'h87, 1'b1);
        tab[5] = make_row(5'h0c, 4'h3, 32'ha5a55a5a, 8'd0, 8'hc3, 1'b0);
        // Extra rows from the LCG with expected values by the op repacking rule
        for (int i = 6; i < NROWS; i++) begin
            seed            = lcg_next(seed);
            tab[i].op       = seed[31:27];
            tab[i].addr     = seed[26:23];
            tab[i].dly      = {6'b0, seed[1:0]};
            seed            = lcg_next(seed);
            tab[i].data     = seed;
            tab[i].exp_op   = 8'((tab[i].op % 16) * 16 + tab[i].addr);
            tab[i].exp_loc  = (tab[i].op >= 16);
        end
    endtask

    // Advance to 2 ns after the next rising edge
    task automatic step_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic compare(input logic [31:0] exp, input logic [31:0] act, input string msg);
        n_chk++;
        if (exp !== act) begin
            n_err++;
            $display("mismatch at %0t ns: %s, expected %h, got %h", $time, msg, exp, act);
        end
    endtask

    // One host strobe queued as expected when it should be accepted
    task automatic send_cmd(input int idx, input bit accepted);
        i_valid = 1'b1;
        i_op    = tab[idx].op;
        i_addr  = tab[idx].addr;
        i_data  = tab[idx].data;
        if (accepted) begin
            exp_q.push_back(idx);
        end
        step_cycle();
        i_valid = 1'b0;
    endtask

    task automatic wait_request(output bit ok);
        int cnt;
        cnt = 0;
        while (!(o_req_loc || o_req_net) && cnt < TMO) begin
            step_cycle();
            cnt++;
        end
        ok = o_req_loc || o_req_net;
        if (!ok) begin
            n_err++;
            $display("timeout at %0t ns: no request raised by the DUT", $time);
        end
    endtask

    ////////////////////
    // Executor model
    ////////////////////

    // Checks each request, then runs the four-phase ack
    task automatic serve_cmds(input int n);
        bit ok;
        int idx;
        int cnt;
        for (int k = 0; k < n; k++) begin
            wait_request(ok);
            if (!ok) return;
            if (exp_q.size() == 0) begin
                n_err++;
                $display("request at %0t ns with no command outstanding", $time);
                return;
            end
            idx = exp_q.pop_front();
            n_issued++;
            compare(32'(tab[idx].exp_loc), 32'(o_req_loc), "local request");
            compare(32'(!tab[idx].exp_loc), 32'(o_req_net), "network request");
            compare(32'(tab[idx].exp_op), 32'(o_op), "issued op");
            compare(tab[idx].data, o_data, "issued data");
            // Ack withheld for the overflow case
            cnt = 0;
            while (hold_ack && cnt < TMO) begin
                step_cycle();
                cnt++;
            end
            if (hold_ack) begin
                n_err++;
                $display("timeout at %0t ns: ack hold never released", $time);
                return;
            end
            repeat (tab[idx].dly) step_cycle();
            i_ack = 1'b1;
            step_cycle();
            compare(32'd0, 32'(o_req_loc || o_req_net), "request after ack");
            i_ack = 1'b0;
            compare(32'(n_issued % 16), 32'(o_data_cntr), "issued counter");
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        bit ok;
        i_clk    = 1'b0;
        i_rstn   = 1'b0;
        i_valid  = 1'b0;
        i_op     = '0;
        i_addr   = '0;
        i_data   = '0;
        i_ack    = 1'b0;
        hold_ack = 1'b0;
        n_err    = 0;
        n_chk    = 0;
        n_issued = 0;
        build_table();
        repeat (2) step_cycle();
        i_rstn = 1'b1;

        // Reset state
        compare(32'd0, 32'(o_req_loc), "local request after reset");
        compare(32'd0, 32'(o_req_net), "network request after reset");
        compare(32'd0, 32'(o_op), "op after reset");
        compare(32'd0, o_data, "data after reset");
        compare(32'd0, 32'(o_data_cntr), "issued counter after reset");
        compare(32'd0, 32'(o_drop_cntr), "drop counter after reset");

        // Each row on an idle path
        for (int r = 0; r < NROWS; r++) begin
            fork
                send_cmd(r, 1'b1);
                serve_cmds(1);
            join
        end

        // Back to back behind a long ack delay on row 0
        fork
            begin
                for (int r = 0; r <= FIFO_DEPTH; r++) begin
                    send_cmd(r, 1'b1);
                end
            end
            serve_cmds(FIFO_DEPTH + 1);
        join
        compare(32'd0, 32'(o_drop_cntr), "drop counter without overflow");

        // Overflow with ack withheld
        hold_ack = 1'b1;
        fork
            begin
                send_cmd(5, 1'b1);
                wait_request(ok);
                if (ok) begin
                    for (int r = 6; r < 6 + FIFO_DEPTH + 2; r++) begin
                        send_cmd(r, r < 6 + FIFO_DEPTH);
                    end
                    compare(32'd2, 32'(o_drop_cntr), "drop counter after overflow");
                end
                hold_ack = 1'b0;
            end
            serve_cmds(FIFO_DEPTH + 1);
        join

        // Dropped commands must never issue
        repeat (4) step_cycle();
        compare(32'd0, 32'(o_req_loc || o_req_net), "request after drain");
        compare(32'd0, 32'(exp_q.size()), "outstanding commands");

        $display("checks: %0d, errors: %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/cmd_fifo.sv ====
////////////////////
// Command FIFO
// First-word-fall-through circular buffer for any packed payload,
// head word shown combinationally along with empty and level
////////////////////
`timescale 1ns/1ps

module cmd_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic                     i_clk,
    input  logic                     i_rstn,
    // Write side
    input  logic                     i_push,
    input  T                         i_wdata,
    // Read side
    input  logic                     i_pop,
    output T                         o_rdata,
    output logic                     o_empty,
    // Occupancy, 0 to DEPTH
    output logic [$clog2(DEPTH):0]   o_level
);

    // Pointer width, at least one bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LVL_W = $clog2(DEPTH) + 1;

    // Storage, payload only
    T                   mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr_r;
    logic [PTR_W-1:0]   rd_ptr_r;
    logic [LVL_W-1:0]   count_r;

    ////////////////////
    // Storage write
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr_r] <= i_wdata;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    // Neighbors never push when full or pop when empty
    // Power of two depth, pointers wrap on their own
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (i_pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({i_push, i_pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    // Head word falls through
    assign o_rdata = mem[rd_ptr_r];
    assign o_empty = (count_r == '0);
    assign o_level = count_r;

endmodule

// ==== hdl/host_cmd_port.sv ====
////////////////////
// Host command port
// Packs host command strobes into a host_cmd_t and writes them
// to the command FIFO, drops and counts strobes while it is full
////////////////////
`timescale 1ns/1ps

module host_cmd_port #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                   i_clk,
    input  logic                                   i_rstn,
    // Host strobe
    input  logic                                   i_valid,
    input  logic [qcom_cmd_pkg::HOST_OP_W-1:0]     i_op,
    input  logic [qcom_cmd_pkg::ADDR_W-1:0]        i_addr,
    input  logic [qcom_cmd_pkg::DATA_W-1:0]        i_data,
    // FIFO occupancy
    input  logic [$clog2(FIFO_DEPTH):0]            i_level,
    // FIFO write side
    output logic                                   o_push,
    output qcom_cmd_pkg::host_cmd_t                o_cmd,
    // Debug
    output logic [qcom_ctrl_pkg::CNTR_W-1:0]       o_drop_cntr
);

    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    logic                                   room;
    logic [qcom_ctrl_pkg::CNTR_W-1:0]       drop_cntr_r;

    // Only fullness test in the path, FIFO itself does not guard
    assign room = (i_level < LVL_W'(FIFO_DEPTH));

    // Command is written into the FIFO slot on the sampling edge
    assign o_push     = i_valid && room;
    assign o_cmd.op   = i_op;
    assign o_cmd.addr = i_addr;
    assign o_cmd.data = i_data;

    ////////////////////
    // Drop counter
    ////////////////////

    // Wraps silently, debug only
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            drop_cntr_r <= '0;
        end else if (i_valid && !room) begin
            drop_cntr_r <= drop_cntr_r + 1'b1;
        end
    end

    assign o_drop_cntr = drop_cntr_r;

endmodule

// ==== hdl/qcom_cmd_pkg.sv ====
////////////////////
// QICK board command formats
// Host command as written by the host side and buffered,
// exec command as presented to the local and network executors
////////////////////
package qcom_cmd_pkg;

    ////////////////////
    // Field widths
    ////////////////////

    // Host side operation code
    localparam int HOST_OP_W = 5;
    // Target address within the board
    localparam int ADDR_W    = 4;
    // Payload word
    localparam int DATA_W    = 32;
    // Repacked op seen by the executors
    localparam int EXEC_OP_W = 8;

    // Host op bit selecting a local request, network otherwise
    localparam int OP_LOC_BIT = 4;

    ////////////////////
    // Command structs
    ////////////////////

    // One host command, also the FIFO payload (41 bits)
    typedef struct packed {
        logic [HOST_OP_W-1:0] op;
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
    } host_cmd_t;

    // Issued command, op is {host op[3:0], addr}
    typedef struct packed {
        logic [EXEC_OP_W-1:0] op;
        logic [DATA_W-1:0]    data;
    } exec_cmd_t;

endpackage

// ==== hdl/qcom_cmd_top.sv ====
////////////////////
// QICK board command path top
// Host port feeds the command FIFO, issue block drains it
// toward the local and network executors
////////////////////
`timescale 1ns/1ps

module qcom_cmd_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    // Host command strobe
    input  logic                                i_valid,
    input  logic [qcom_cmd_pkg::HOST_OP_W-1:0]  i_op,
    input  logic [qcom_cmd_pkg::ADDR_W-1:0]     i_addr,
    input  logic [qcom_cmd_pkg::DATA_W-1:0]     i_data,
    // Executor handshake
    input  logic                                i_ack,
    output logic                                o_req_loc,
    output logic                                o_req_net,
    output logic [qcom_cmd_pkg::EXEC_OP_W-1:0]  o_op,
    output logic [qcom_cmd_pkg::DATA_W-1:0]     o_data,
    // Debug counters
    output logic [qcom_ctrl_pkg::CNTR_W-1:0]    o_data_cntr,
    output logic [qcom_ctrl_pkg::CNTR_W-1:0]    o_drop_cntr
);

    import qcom_cmd_pkg::*;

    // Producer to buffer
    logic                           push;
    host_cmd_t                      push_cmd;
    logic [$clog2(FIFO_DEPTH):0]    level;
    // Buffer to consumer
    host_cmd_t                      head_cmd;
    logic                           empty;
    logic                           pop;
    // Consumer to executors
    exec_cmd_t                      exec_cmd;

    host_cmd_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_port (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .i_level     (level),
        .o_push      (push),
        .o_cmd       (push_cmd),
        .o_drop_cntr (o_drop_cntr)
    );

    cmd_fifo #(
        .T     (host_cmd_t),
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_push  (push),
        .i_wdata (push_cmd),
        .i_pop   (pop),
        .o_rdata (head_cmd),
        .o_empty (empty),
        .o_level (level)
    );

    req_ack_cmd i_issue (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_empty     (empty),
        .i_cmd       (head_cmd),
        .o_pop       (pop),
        .i_ack       (i_ack),
        .o_req_loc   (o_req_loc),
        .o_req_net   (o_req_net),
        .o_cmd       (exec_cmd),
        .o_data_cntr (o_data_cntr)
    );

    // Split issued command onto the executor bus
    assign o_op   = exec_cmd.op;
    assign o_data = exec_cmd.data;

endmodule

// ==== hdl/qcom_ctrl_pkg.sv ====
////////////////////
// QICK command path control definitions
// Issue FSM encoding and debug counter widths
////////////////////
package qcom_ctrl_pkg;

    // Issued and dropped command counters, free running and wrapping
    localparam int CNTR_W = 4;

    // Issue FSM state register width
    localparam int STATE_W = 2;

    ////////////////////
    // Issue FSM states
    ////////////////////

    // IDLE     waiting for a buffered command
    // LOC_REQ  local request held until ack
    // NET_REQ  network request held until ack
    // ACK      request dropped, waiting for ack to fall
    typedef enum logic [STATE_W-1:0] {
        IDLE    = 2'b00,
        LOC_REQ = 2'b01,
        NET_REQ = 2'b10,
        ACK     = 2'b11
    } issue_state_t;

endpackage

// ==== hdl/req_ack_cmd.sv ====
////////////////////
// Command issue with four-phase handshake
// Pops one buffered command, raises a local or network request
// with the repacked op and data, then waits for ack to rise and fall
////////////////////
`timescale 1ns/1ps

module req_ack_cmd (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    // FIFO read side
    input  logic                                i_empty,
    input  qcom_cmd_pkg::host_cmd_t             i_cmd,
    output logic                                o_pop,
    // Executor handshake
    input  logic                                i_ack,
    output logic                                o_req_loc,
    output logic                                o_req_net,
    output qcom_cmd_pkg::exec_cmd_t             o_cmd,
    // Debug
    output logic [qcom_ctrl_pkg::CNTR_W-1:0]    o_data_cntr
);

    import qcom_cmd_pkg::*;
    import qcom_ctrl_pkg::*;

    issue_state_t           state_r;
    issue_state_t           state_n;

    logic                   req_loc_r;
    logic                   req_net_r;
    exec_cmd_t              cmd_r;
    logic [CNTR_W-1:0]      cntr_r;

    // Take the head word only when idle
    assign o_pop = (state_r == IDLE) && !i_empty;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_n = state_r;
        case (state_r)
            IDLE: begin
                // Op bit picks local vs network executor
                if (o_pop) begin
                    state_n = i_cmd.op[OP_LOC_BIT] ? LOC_REQ : NET_REQ;
                end
            end
            LOC_REQ, NET_REQ: begin
                // Hold request until ack rises
                if (i_ack) begin
                    state_n = ACK;
                end
            end
            ACK: begin
                // Back to idle once ack released
                if (!i_ack) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    ////////////////////
    // State and requests
    ////////////////////

    // Requests registered from next state, in step with op and data
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state_r   <= IDLE;
            req_loc_r <= 1'b0;
            req_net_r <= 1'b0;
        end else begin
            state_r   <= state_n;
            req_loc_r <= (state_n == LOC_REQ);
            req_net_r <= (state_n == NET_REQ);
        end
    end

    // Command latch and issued counter, loaded on pop
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            cmd_r  <= '0;
            cntr_r <= '0;
        end else if (o_pop) begin
            cmd_r.op   <= {i_cmd.op[3:0], i_cmd.addr};
            cmd_r.data <= i_cmd.data;
            cntr_r     <= cntr_r + 1'b1;
        end
    end

    assign o_req_loc   = req_loc_r;
    assign o_req_net   = req_net_r;
    assign o_cmd       = cmd_r;
    assign o_data_cntr = cntr_r;

endmodule

// ==== qcom_cmd.f ====
hdl/qcom_cmd_pkg.sv
hdl/qcom_ctrl_pkg.sv
hdl/host_cmd_port.sv
hdl/cmd_fifo.sv
hdl/req_ack_cmd.sv
hdl/qcom_cmd_top.sv
dv/qcom_cmd_properties.sv
dv/qcom_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the command path testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module qcom_cmd_tb -f qcom_cmd.f \
    && ./obj_dir/Vqcom_cmd_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
